// ==== include/mips_ex_params.svh ====
`ifndef MIPS_EX_PARAMS_SVH
`define MIPS_EX_PARAMS_SVH

// Datapath widths
`define MIPS_LEN        32
`define NB_REG_ADDR     5
`define NB_OPCODE       6
`define NB_FUNCT        6
`define NB_IMM          16
`define NB_ALU_CONTROL  4
`define NB_ALU_CLASS    4

// Pipeline control field widths
`define NB_CTRL_WB      2
`define NB_CTRL_MEM     9
`define NB_CTRL_EX      8

// Memory access size code for a full word
`define MEM_SIZE_WORD   2'b11

// Opcodes
`define OP_RTYPE        6'h00
`define OP_J            6'h02
`define OP_BEQ          6'h04
`define OP_BNE          6'h05
`define OP_ADDI         6'h08
`define OP_ADDIU        6'h09
`define OP_SLTI         6'h0a
`define OP_SLTIU        6'h0b
`define OP_ANDI         6'h0c
`define OP_ORI          6'h0d
`define OP_XORI         6'h0e
`define OP_LUI          6'h0f
`define OP_LW           6'h23
`define OP_SW           6'h2b

// R-type funct codes
`define FN_SLL          6'h00
`define FN_SRL          6'h02
`define FN_SRA          6'h03
`define FN_SLLV         6'h04
`define FN_SRLV         6'h06
`define FN_SRAV         6'h07
`define FN_ADD          6'h20
`define FN_ADDU         6'h21
`define FN_SUB          6'h22
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_XOR          6'h26
`define FN_NOR          6'h27
`define FN_SLT          6'h2a
`define FN_SLTU         6'h2b

`endif

// ==== source/mips_ex_pkg.sv ====
`default_nettype none

`include "mips_ex_params.svh"

package mips_ex_pkg;

    typedef logic [`MIPS_LEN-1:0]    word_t;
    typedef logic [`NB_REG_ADDR-1:0] reg_addr_t;

    // {RegWrite, MemToReg}
    typedef logic [`NB_CTRL_WB-1:0]  ctrl_wb_t;
    // {Branch, BranchNe, MemRead, MemWrite, size[1:0], unsigned, Jump, rsvd}
    typedef logic [`NB_CTRL_MEM-1:0] ctrl_mem_t;
    // {RegDst, ALUSrc1, ALUSrc2, Jump, alu_code[3:0]}
    typedef logic [`NB_CTRL_EX-1:0]  ctrl_ex_t;

    typedef enum logic [`NB_ALU_CONTROL-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_t;

    // Coarse operation class from the main decoder
    typedef enum logic [`NB_ALU_CLASS-1:0] {
        CLS_ADD   = 4'd0,
        CLS_SUB   = 4'd1,
        CLS_FUNCT = 4'd2,
        CLS_AND   = 4'd3,
        CLS_OR    = 4'd4,
        CLS_XOR   = 4'd5,
        CLS_SLT   = 4'd6,
        CLS_SLTU  = 4'd7,
        CLS_LUI   = 4'd8
    } alu_class_t;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_params.svh"

module instr_decoder
    import mips_ex_pkg::*;
(
    input  wire logic [`NB_OPCODE-1:0] i_opcode,
    input  wire logic [`NB_IMM-1:0]    i_imm,
    output ctrl_wb_t                   o_ctrl_wb,
    output ctrl_mem_t                  o_ctrl_mem,
    output logic                       o_reg_dst,
    output logic                       o_alu_src2,
    output logic                       o_jump,
    output alu_class_t                 o_alu_class,
    output word_t                      o_imm_ext
);

    logic       reg_write;
    logic       mem_to_reg;
    logic       branch;
    logic       branch_ne;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] mem_size;
    logic       zero_ext;

    ////////////////////
    // Main control
    ////////////////////
    always_comb
    begin
        // Unknown opcodes fall through with everything cleared
        reg_write   = 1'b0;
        mem_to_reg  = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_size    = 2'b00;
        zero_ext    = 1'b0;
        o_reg_dst   = 1'b0;
        o_alu_src2  = 1'b0;
        o_jump      = 1'b0;
        o_alu_class = CLS_ADD;

        case (i_opcode)
            `OP_RTYPE:
            begin
                reg_write   = 1'b1;
                o_reg_dst   = 1'b1;
                o_alu_class = CLS_FUNCT;
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LUI:
            begin
                reg_write  = 1'b1;
                o_alu_src2 = 1'b1;
                case (i_opcode)
                    `OP_SLTI:  o_alu_class = CLS_SLT;
                    `OP_SLTIU: o_alu_class = CLS_SLTU;
                    `OP_LUI:   o_alu_class = CLS_LUI;
                    default:   o_alu_class = CLS_ADD;
                endcase
            end
            `OP_ANDI, `OP_ORI, `OP_XORI:
            begin
                // Logical immediates take the zero-extended form
                reg_write  = 1'b1;
                o_alu_src2 = 1'b1;
                zero_ext   = 1'b1;
                case (i_opcode)
                    `OP_ANDI: o_alu_class = CLS_AND;
                    `OP_ORI:  o_alu_class = CLS_OR;
                    default:  o_alu_class = CLS_XOR;
                endcase
            end
            `OP_LW:
            begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                mem_read   = 1'b1;
                mem_size   = `MEM_SIZE_WORD;
                o_alu_src2 = 1'b1;
            end
            `OP_SW:
            begin
                mem_write  = 1'b1;
                mem_size   = `MEM_SIZE_WORD;
                o_alu_src2 = 1'b1;
            end
            // Subtract so the zero flag shows equality
            `OP_BEQ:
            begin
                branch      = 1'b1;
                o_alu_class = CLS_SUB;
            end
            `OP_BNE:
            begin
                branch_ne   = 1'b1;
                o_alu_class = CLS_SUB;
            end
            `OP_J:      o_jump = 1'b1;
            default:    o_jump = 1'b0;
        endcase
    end

    assign o_ctrl_wb  = {reg_write, mem_to_reg};
    // Loads are word-only, so the unsigned bit stays low
    assign o_ctrl_mem = {branch, branch_ne, mem_read, mem_write, mem_size,
                         1'b0, o_jump, 1'b0};

    assign o_imm_ext = zero_ext ? {{(`MIPS_LEN-`NB_IMM){1'b0}}, i_imm}
                                : {{(`MIPS_LEN-`NB_IMM){i_imm[`NB_IMM-1]}}, i_imm};

endmodule

`default_nettype wire

// ==== source/alu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_params.svh"

module alu_control
    import mips_ex_pkg::*;
(
    input  wire alu_class_t           i_alu_class,
    input  wire logic [`NB_FUNCT-1:0] i_funct,
    output alu_op_t                   o_alu_op,
    output logic                      o_alu_src1
);

    ////////////////////
    // Funct decode
    ////////////////////
    always_comb
    begin
        o_alu_op   = ALU_ADD;
        o_alu_src1 = 1'b0;

        case (i_alu_class)
            CLS_FUNCT:
            begin
                case (i_funct)
                    `FN_ADD, `FN_ADDU: o_alu_op = ALU_ADD;
                    `FN_SUB, `FN_SUBU: o_alu_op = ALU_SUB;
                    `FN_AND:           o_alu_op = ALU_AND;
                    `FN_OR:            o_alu_op = ALU_OR;
                    `FN_XOR:           o_alu_op = ALU_XOR;
                    `FN_NOR:           o_alu_op = ALU_NOR;
                    `FN_SLT:           o_alu_op = ALU_SLT;
                    `FN_SLTU:          o_alu_op = ALU_SLTU;
                    // Variable shifts take the amount from rs
                    `FN_SLLV:          o_alu_op = ALU_SLL;
                    `FN_SRLV:          o_alu_op = ALU_SRL;
                    `FN_SRAV:          o_alu_op = ALU_SRA;
                    `FN_SLL:
                    begin
                        o_alu_op   = ALU_SLL;
                        o_alu_src1 = 1'b1;
                    end
                    `FN_SRL:
                    begin
                        o_alu_op   = ALU_SRL;
                        o_alu_src1 = 1'b1;
                    end
                    `FN_SRA:
                    begin
                        o_alu_op   = ALU_SRA;
                        o_alu_src1 = 1'b1;
                    end
                    default:           o_alu_op = ALU_ADD;
                endcase
            end
            CLS_SUB:  o_alu_op = ALU_SUB;
            CLS_AND:  o_alu_op = ALU_AND;
            CLS_OR:   o_alu_op = ALU_OR;
            CLS_XOR:  o_alu_op = ALU_XOR;
            CLS_SLT:  o_alu_op = ALU_SLT;
            CLS_SLTU: o_alu_op = ALU_SLTU;
            CLS_LUI:  o_alu_op = ALU_LUI;
            default:  o_alu_op = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_params.svh"

module alu
    import mips_ex_pkg::*;
(
    input  wire word_t   i_dato_a,
    input  wire word_t   i_dato_b,
    input  wire alu_op_t i_opcode,
    output word_t        o_result,
    output logic         o_zero_flag
);

    localparam int HALF = `MIPS_LEN / 2;

    // Shift amount comes from the low bits of A
    logic [`NB_REG_ADDR-1:0] shamt;

    assign shamt = i_dato_a[`NB_REG_ADDR-1:0];

    always_comb
    begin
        case (i_opcode)
            ALU_ADD:  o_result = i_dato_a + i_dato_b;
            ALU_SUB:  o_result = i_dato_a - i_dato_b;
            ALU_AND:  o_result = i_dato_a & i_dato_b;
            ALU_OR:   o_result = i_dato_a | i_dato_b;
            ALU_XOR:  o_result = i_dato_a ^ i_dato_b;
            ALU_NOR:  o_result = ~(i_dato_a | i_dato_b);
            ALU_SLT:
            begin
                o_result = '0;
                o_result[0] = $signed(i_dato_a) < $signed(i_dato_b);
            end
            ALU_SLTU:
            begin
                o_result = '0;
                o_result[0] = i_dato_a < i_dato_b;
            end
            // Shifts operate on B
            ALU_SLL:  o_result = i_dato_b << shamt;
            ALU_SRL:  o_result = i_dato_b >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_dato_b) >>> shamt);
            ALU_LUI:  o_result = {i_dato_b[HALF-1:0], {HALF{1'b0}}};
            default:  o_result = '0;
        endcase
    end

    assign o_zero_flag = (o_result == '0);

endmodule

`default_nettype wire

// ==== source/tl_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_params.svh"

module tl_execute
    import mips_ex_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire word_t     i_adder_id,
    input  wire word_t     i_dato1,
    input  wire word_t     i_dato2,
    input  wire word_t     i_sign_extend,
    input  wire ctrl_wb_t  i_ctrl_wb,
    input  wire ctrl_mem_t i_ctrl_mem,
    // RegDst, ALUSrc1, ALUSrc2, Jump, alu_code
    input  wire ctrl_ex_t  i_ctrl_ex,
    input  wire reg_addr_t i_rd,
    input  wire reg_addr_t i_rt,
    input  wire reg_addr_t i_shamt,
    output logic           o_alu_zero,
    output reg_addr_t      o_write_reg,
    output ctrl_wb_t       o_ctrl_wb,
    output ctrl_mem_t      o_ctrl_mem,
    output word_t          o_add_execute,
    output word_t          o_alu_result,
    output word_t          o_dato2
);

    logic    reg_dst;
    logic    alu_src1;
    logic    alu_src2;
    alu_op_t alu_op;

    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    reg_addr_t write_reg;
    word_t     add_execute;

    assign reg_dst  = i_ctrl_ex[7];
    assign alu_src1 = i_ctrl_ex[6];
    assign alu_src2 = i_ctrl_ex[5];
    assign alu_op   = alu_op_t'(i_ctrl_ex[`NB_ALU_CONTROL-1:0]);

    ////////////////////
    // Operand muxes
    ////////////////////
    assign alu_a = alu_src1 ? {{(`MIPS_LEN-`NB_REG_ADDR){1'b0}}, i_shamt} : i_dato1;
    assign alu_b = alu_src2 ? i_sign_extend : i_dato2;

    assign write_reg = reg_dst ? i_rd : i_rt;

    // Branch target from the word offset
    assign add_execute = i_adder_id + {i_sign_extend[`MIPS_LEN-3:0], 2'b00};

    alu u_alu
    (
        .i_dato_a    (alu_a),
        .i_dato_b    (alu_b),
        .i_opcode    (alu_op),
        .o_result    (alu_result),
        .o_zero_flag (alu_zero)
    );

    ////////////////////
    // EX/MEM register, falling edge
    ////////////////////
    always_ff @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            o_add_execute <= '0;
            o_alu_result  <= '0;
            o_dato2       <= '0;
            o_ctrl_wb     <= '0;
            o_ctrl_mem    <= '0;
            o_write_reg   <= '0;
            o_alu_zero    <= 1'b0;
        end
        else
        begin
            o_add_execute <= add_execute;
            o_alu_result  <= alu_result;
            // Store data for sw
            o_dato2       <= i_dato2;
            o_ctrl_wb     <= i_ctrl_wb;
            o_ctrl_mem    <= i_ctrl_mem;
            o_write_reg   <= write_reg;
            o_alu_zero    <= alu_zero;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_params.svh"

module ex_subsystem_top
    import mips_ex_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst,
    input  wire word_t i_instr,
    input  wire word_t i_pc_plus4,
    input  wire word_t i_dato1,
    input  wire word_t i_dato2,
    output logic       o_alu_zero,
    output reg_addr_t  o_write_reg,
    output ctrl_wb_t   o_ctrl_wb,
    output ctrl_mem_t  o_ctrl_mem,
    output word_t      o_add_execute,
    output word_t      o_alu_result,
    output word_t      o_dato2
);

    // Instruction fields
    logic [`NB_OPCODE-1:0] opcode;
    reg_addr_t             rt;
    reg_addr_t             rd;
    reg_addr_t             shamt;
    logic [`NB_FUNCT-1:0]  funct;
    logic [`NB_IMM-1:0]    imm;

    assign opcode = i_instr[31:26];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign funct  = i_instr[5:0];
    assign imm    = i_instr[15:0];

    ctrl_wb_t   ctrl_wb;
    ctrl_mem_t  ctrl_mem;
    ctrl_ex_t   ctrl_ex;
    logic       reg_dst;
    logic       alu_src1;
    logic       alu_src2;
    logic       jump;
    alu_class_t alu_class;
    alu_op_t    alu_op;
    word_t      imm_ext;

    instr_decoder u_instr_decoder
    (
        .i_opcode    (opcode),
        .i_imm       (imm),
        .o_ctrl_wb   (ctrl_wb),
        .o_ctrl_mem  (ctrl_mem),
        .o_reg_dst   (reg_dst),
        .o_alu_src2  (alu_src2),
        .o_jump      (jump),
        .o_alu_class (alu_class),
        .o_imm_ext   (imm_ext)
    );

    alu_control u_alu_control
    (
        .i_alu_class (alu_class),
        .i_funct     (funct),
        .o_alu_op    (alu_op),
        .o_alu_src1  (alu_src1)
    );

    // Execute control word
    assign ctrl_ex = {reg_dst, alu_src1, alu_src2, jump, alu_op};

    tl_execute u_tl_execute
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_adder_id    (i_pc_plus4),
        .i_dato1       (i_dato1),
        .i_dato2       (i_dato2),
        .i_sign_extend (imm_ext),
        .i_ctrl_wb     (ctrl_wb),
        .i_ctrl_mem    (ctrl_mem),
        .i_ctrl_ex     (ctrl_ex),
        .i_rd          (rd),
        .i_rt          (rt),
        .i_shamt       (shamt),
        .o_alu_zero    (o_alu_zero),
        .o_write_reg   (o_write_reg),
        .o_ctrl_wb     (o_ctrl_wb),
        .o_ctrl_mem    (o_ctrl_mem),
        .o_add_execute (o_add_execute),
        .o_alu_result  (o_alu_result),
        .o_dato2       (o_dato2)
    );

endmodule

`default_nettype wire

// ==== verification/tb_ex_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_ex_params.svh"

module tb_ex_subsystem
    import mips_ex_pkg::*;
();

    localparam int  HALF_PERIOD     = 20;
    localparam int  RESET_CYCLES    = 8;
    localparam int  NUM_INSTR       = 3000;
    localparam time EDGE_TIMEOUT_NS = 200;

    logic      clk = 1'b0;
    logic      rst;
    word_t     instr;
    word_t     pc_plus4;
    word_t     dato1;
    word_t     dato2;
    logic      alu_zero;
    reg_addr_t write_reg;
    ctrl_wb_t  ctrl_wb;
    ctrl_mem_t ctrl_mem;
    word_t     add_execute;
    word_t     alu_result;
    word_t     dato2_out;

    // Expected EX/MEM contents for the instruction last driven
    logic      exp_zero;
    reg_addr_t exp_wr;
    ctrl_wb_t  exp_wb;
    ctrl_mem_t exp_mem;
    word_t     exp_add;
    word_t     exp_res;
    word_t     exp_d2;

    word_t nxt_instr;
    word_t nxt_pc;
    word_t nxt_a;
    word_t nxt_b;
    word_t rng;
    int    n_checks;
    int    n_errors;
    logic  timed_out;

    logic [5:0] funct_list [16] = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
                                    `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL,
                                    `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV};
    logic [5:0] op_list [13]    = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI,
                                    `OP_ORI, `OP_XORI, `OP_LUI, `OP_LW, `OP_SW, `OP_BEQ,
                                    `OP_BNE, `OP_J};
    // Opcodes the stage does not implement
    logic [5:0] bad_ops [8]     = '{6'h01, 6'h03, 6'h06, 6'h07, 6'h10, 6'h1c, 6'h20, 6'h3f};

    ex_subsystem_top dut_i
    (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr       (instr),
        .i_pc_plus4    (pc_plus4),
        .i_dato1       (dato1),
        .i_dato2       (dato2),
        .o_alu_zero    (alu_zero),
        .o_write_reg   (write_reg),
        .o_ctrl_wb     (ctrl_wb),
        .o_ctrl_mem    (ctrl_mem),
        .o_add_execute (add_execute),
        .o_alu_result  (alu_result),
        .o_dato2       (dato2_out)
    );

    initial
    begin
        forever #HALF_PERIOD clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic word_t lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic word_t rtype_result(input logic [5:0] fn, input logic [4:0] sh,
                                           input word_t a, input word_t b);
        case (fn)
            `FN_SUB, `FN_SUBU: return a - b;
            `FN_AND:           return a & b;
            `FN_OR:            return a | b;
            `FN_XOR:           return a ^ b;
            `FN_NOR:           return ~(a | b);
            `FN_SLT:           return {31'd0, $signed(a) < $signed(b)};
            `FN_SLTU:          return {31'd0, a < b};
            `FN_SLL:           return b << sh;
            `FN_SRL:           return b >> sh;
            `FN_SRA:           return $signed(b) >>> sh;
            // Variable forms shift rt by the low bits of rs
            `FN_SLLV:          return b << a[4:0];
            `FN_SRLV:          return b >> a[4:0];
            `FN_SRAV:          return $signed(b) >>> a[4:0];
            default:           return a + b;
        endcase
    endfunction

    task automatic predict_outputs(input word_t ins, input word_t pc,
                                   input word_t a, input word_t b);
        logic [5:0] op;
        word_t      ext;
        word_t      res;
        begin
            op = ins[31:26];
            ext = {{16{ins[15]}}, ins[15:0]};
            if (op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI)
                ext = {16'h0000, ins[15:0]};
            exp_wr = (op == `OP_RTYPE) ? ins[15:11] : ins[20:16];
            exp_d2 = b;
            exp_add = pc + (ext << 2);

            case (op)
                `OP_RTYPE, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
                    exp_wb = 2'b10;
                `OP_LW:  exp_wb = 2'b11;
                default: exp_wb = 2'b00;
            endcase

            // Branch, BranchNe, MemRead, MemWrite, size, unsigned, Jump, rsvd
            case (op)
                `OP_LW:  exp_mem = 9'b0010_11_000;
                `OP_SW:  exp_mem = 9'b0001_11_000;
                `OP_BEQ: exp_mem = 9'b1000_00_000;
                `OP_BNE: exp_mem = 9'b0100_00_000;
                `OP_J:   exp_mem = 9'b0000_00_010;
                default: exp_mem = '0;
            endcase

            case (op)
                `OP_RTYPE:                          res = rtype_result(ins[5:0], ins[10:6], a, b);
                `OP_ADDI, `OP_ADDIU, `OP_LW, `OP_SW: res = a + ext;
                `OP_SLTI:                           res = {31'd0, $signed(a) < $signed(ext)};
                `OP_SLTIU:                          res = {31'd0, a < ext};
                `OP_ANDI:                           res = a & ext;
                `OP_ORI:                            res = a | ext;
                `OP_XORI:                           res = a ^ ext;
                `OP_LUI:                            res = {ins[15:0], 16'h0000};
                `OP_BEQ, `OP_BNE:                   res = a - b;
                default:                            res = a + b;
            endcase
            exp_res = res;
            exp_zero = (res == 32'd0);
        end
    endtask

    task automatic pick_stimulus();
        word_t       r;
        word_t       fields;
        int unsigned idx;
        begin
            nxt_pc = lcg_next() & 32'hffff_fffc;
            nxt_a = lcg_next();
            nxt_b = lcg_next();
            fields = lcg_next();
            r = lcg_next();
            // Equal operands now and then so branches see a zero result
            if (r[31:30] == 2'b00)
                nxt_b = nxt_a;
            idx = r[19:8] % 29;
            if (r[27:24] == 4'h0)
                nxt_instr = {bad_ops[r[22:20]], fields[25:0]};
            else if (idx < 16)
                nxt_instr = {`OP_RTYPE, fields[25:6], funct_list[idx[3:0]]};
            else
                nxt_instr = {op_list[4'(idx - 16)], fields[25:0]};
            predict_outputs(nxt_instr, nxt_pc, nxt_a, nxt_b);
        end
    endtask

    task automatic check_value(input string name, input word_t act, input word_t exp);
        n_checks++;
        assert (act === exp)
        else
        begin
            n_errors++;
            $display("Mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, exp, act);
        end
    endtask

    task automatic compare_outputs(input logic in_reset);
        begin
            check_value("o_alu_zero", 32'(alu_zero), in_reset ? '0 : 32'(exp_zero));
            check_value("o_write_reg", 32'(write_reg), in_reset ? '0 : 32'(exp_wr));
            check_value("o_ctrl_wb", 32'(ctrl_wb), in_reset ? '0 : 32'(exp_wb));
            check_value("o_ctrl_mem", 32'(ctrl_mem), in_reset ? '0 : 32'(exp_mem));
            check_value("o_add_execute", add_execute, in_reset ? '0 : exp_add);
            check_value("o_alu_result", alu_result, in_reset ? '0 : exp_res);
            check_value("o_dato2", dato2_out, in_reset ? '0 : exp_d2);
        end
    endtask

    // Wait for the next rising edge within a time bound
    task automatic wait_rise();
        time  deadline;
        logic rose;
        begin
            deadline = $time + EDGE_TIMEOUT_NS;
            rose = 1'b0;
            fork
                begin
                    @(posedge clk);
                    rose = 1'b1;
                end
                begin
                    while (!rose && $time < deadline)
                        #1;
                end
            join_any
            disable fork;
            if (!rose)
            begin
                n_errors++;
                timed_out = 1'b1;
                $display("Timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT_NS);
            end
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        rst = 1'b0;
        instr = '0;
        pc_plus4 = '0;
        dato1 = '0;
        dato2 = '0;
        rng = 32'h52b3_d114;
        n_checks = 0;
        n_errors = 0;
        timed_out = 1'b0;

        for (int cyc = 1; cyc <= RESET_CYCLES + NUM_INSTR && !timed_out; cyc++)
        begin
            wait_rise();
            if (!timed_out)
            begin
                // Outputs stay cleared through reset and at its release
                if (cyc <= RESET_CYCLES && cyc > 1)
                    compare_outputs(1'b1);
                else if (cyc > RESET_CYCLES)
                    compare_outputs(1'b0);
                if (cyc == RESET_CYCLES)
                    rst <= 1'b1;
                pick_stimulus();
                instr    <= nxt_instr;
                pc_plus4 <= nxt_pc;
                dato1    <= nxt_a;
                dato2    <= nxt_b;
            end
        end

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/mips_ex_pkg.sv
source/instr_decoder.sv
source/alu_control.sv
source/alu.sv
source/tl_execute.sv
source/ex_subsystem_top.sv
verification/tb_ex_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute-stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ex_subsystem -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
grep -q "^TEST PASSED$" sim.log && echo "Result: pass" && exit 0 \
    || { echo "Result: fail, see sim.log"; exit 1; }
